//--- Bender.yml
package:
  name: branch_subsystem

sources:
  - branch_pkg.sv
  - branch_decode.sv
  - branch_compare.sv
  - branch_target.sv
  - return_stack.sv
  - branch_resolve.sv
  - branch_subsystem.sv
  - target: simulation
    files:
      - branch_subsystem_tb.sv

//--- branch_compare.sv
// ########################################
// compares rs1 against rs2 one stage early
// funct3 010/011 give a false condition
// ########################################
`timescale 1ns/1ps
`default_nettype none

module branch_compare (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 advance,
    input  logic                 op_valid,
    input  branch_pkg::br_op_t   op,
    output branch_pkg::cmp_res_t cmp
);
    import branch_pkg::*;

    logic               eq;
    logic               lt;
    logic               cond;
    logic signed [32:0] a_ext;
    logic signed [32:0] b_ext;

    assign eq = (op.rs1 == op.rs2);

    // extra top bit is the sign, or zero for unsigned compares
    assign a_ext = {op.rs1[31] & ~op.unsigned_cmp, op.rs1};
    assign b_ext = {op.rs2[31] & ~op.unsigned_cmp, op.rs2};
    assign lt    = (a_ext < b_ext);

    always_comb begin
        case (op.fn3)
            fn3_beq:  cond = eq;
            fn3_bne:  cond = ~eq;
            fn3_blt:  cond = lt;
            fn3_bge:  cond = ~lt;
            fn3_bltu: cond = lt;
            fn3_bgeu: cond = ~lt;
            default:  cond = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cmp.is_branch <= 1'b0;
        end else if (advance) begin
            // only a live branch takes its condition into account
            cmp.is_branch <= op_valid & op.is_branch;
            cmp.cond_true <= cond;
        end
    end

    a_fn3_legal: assert property (@(posedge clk) disable iff (rst)
        (op_valid && op.is_branch) |-> !(op.fn3 inside {3'b010, 3'b011}))
        else $error("reserved funct3 on a branch");

endmodule

`default_nettype wire

//--- branch_decode.sv
// ########################################
// only branch, jal and jalr are decoded
// other opcodes pass with all kind flags 0
// ########################################
`timescale 1ns/1ps
`default_nettype none

module branch_decode (
    input  logic                clk,
    input  logic                rst,
    input  logic                advance,
    input  logic                req_valid,
    input  branch_pkg::br_req_t req,
    output logic                op_valid,
    output branch_pkg::br_op_t  op
);
    import branch_pkg::*;

    br_op_t     op_d;
    logic [4:0] rd;
    logic [4:0] rs1_idx;
    logic       rd_link;
    logic       rs1_link;

    // rd and rs1 sit at the same bits in the J and I layouts
    assign rd       = req.instr.i.rd;
    assign rs1_idx  = req.instr.i.rs1;
    assign rd_link  = (rd == reg_ra) || (rd == reg_t0);
    assign rs1_link = (rs1_idx == reg_ra) || (rs1_idx == reg_t0);

    always_comb begin
        op_d           = '0;
        op_d.fn3       = req.instr.b.funct3;
        op_d.pc        = req.pc;
        op_d.rs1       = req.rs1;
        op_d.rs2       = req.rs2;
        op_d.pred_taken = req.pred_taken;
        op_d.rd_zero   = (rd == 5'd0);
        // bltu and bgeu compare without sign
        op_d.unsigned_cmp = (req.instr.b.funct3 == fn3_bltu)
                         || (req.instr.b.funct3 == fn3_bgeu);
        // opcode read once, immediate through the matching view
        case (req.instr.i.opcode)
            op_branch: begin
                op_d.is_branch = 1'b1;
                op_d.offset = {{19{req.instr.b.imm12}}, req.instr.b.imm12,
                               req.instr.b.imm11, req.instr.b.imm10_5,
                               req.instr.b.imm4_1, 1'b0};
            end
            op_jal: begin
                op_d.is_jal = 1'b1;
                op_d.offset = {{11{req.instr.j.imm20}}, req.instr.j.imm20,
                               req.instr.j.imm19_12, req.instr.j.imm11,
                               req.instr.j.imm10_1, 1'b0};
            end
            op_jalr: begin
                op_d.is_jalr = 1'b1;
                op_d.offset = {{20{req.instr.i.imm11_0[11]}}, req.instr.i.imm11_0};
            end
            default: begin
                op_d.offset = '0;
            end
        endcase
        // link register as rd marks a call
        op_d.is_call = (op_d.is_jal || op_d.is_jalr) && rd_link;
        // link register as rs1 marks a return, unless rd repeats it
        op_d.is_return = op_d.is_jalr && rs1_link && (!rd_link || (rd != rs1_idx));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else if (advance) begin
            op_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            op <= op_d;
        end
    end

    a_one_kind: assert property (@(posedge clk) disable iff (rst)
        op_valid |-> $onehot0({op.is_branch, op.is_jal, op.is_jalr}))
        else $error("decode produced more than one transfer kind");

endmodule

`default_nettype wire

//--- branch_pkg.sv
// ########################################
// RV32I only, XLEN fixed at 32 bits
// no compressed encodings are recognised
// ########################################
`default_nettype none

package branch_pkg;

    typedef logic [31:0] xlen_t;

    // funct3 of conditional branches
    // 010 and 011 are not defined by the ISA
    typedef enum logic [2:0] {
        fn3_beq  = 3'b000,
        fn3_bne  = 3'b001,
        fn3_blt  = 3'b100,
        fn3_bge  = 3'b101,
        fn3_bltu = 3'b110,
        fn3_bgeu = 3'b111
    } branch_fn3_t;

    // major opcodes of the control transfers
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // link registers used by the call/return hints
    localparam logic [4:0] reg_ra = 5'd1;
    localparam logic [4:0] reg_t0 = 5'd5;

    // B-type, msb first
    typedef struct packed {
        logic        imm12;
        logic [5:0]  imm10_5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        branch_fn3_t funct3;
        logic [3:0]  imm4_1;
        logic        imm11;
        logic [6:0]  opcode;
    } b_fmt_t;

    // J-type, immediate bits scrambled as in the spec
    typedef struct packed {
        logic        imm20;
        logic [9:0]  imm10_1;
        logic        imm11;
        logic [7:0]  imm19_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } j_fmt_t;

    // I-type, used for jalr
    typedef struct packed {
        logic [11:0] imm11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // one instruction word, three views
    typedef union packed {
        b_fmt_t b;
        j_fmt_t j;
        i_fmt_t i;
    } instr_u;

    typedef struct packed {
        instr_u instr;
        xlen_t  pc;
        xlen_t  rs1;
        xlen_t  rs2;
        logic   pred_taken;
    } br_req_t;

    typedef struct packed {
        logic        is_branch;
        logic        is_jal;
        logic        is_jalr;
        branch_fn3_t fn3;
        logic        unsigned_cmp;
        xlen_t       offset;
        logic        rd_zero;
        logic        is_call;
        logic        is_return;
        xlen_t       pc;
        xlen_t       rs1;
        xlen_t       rs2;
        logic        pred_taken;
    } br_op_t;

    typedef struct packed {
        logic cond_true;
        logic is_branch;
    } cmp_res_t;

    typedef struct packed {
        xlen_t target;
        xlen_t link;
        logic  is_jump;
        logic  rd_zero;
        logic  is_call;
        logic  is_return;
        xlen_t pc;
        logic  pred_taken;
    } tgt_res_t;

    typedef struct packed {
        xlen_t pc;
        logic  taken;
        xlen_t target;
        xlen_t link;
        logic  link_valid;
        logic  is_call;
        logic  is_return;
        logic  mispredict;
    } br_res_t;

endpackage

`default_nettype wire

//--- branch_resolve.sv
// ########################################
// reads the stack top before its update
// stack moves only when a valid op loads
// ########################################
`timescale 1ns/1ps
`default_nettype none

module branch_resolve (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 advance,
    input  logic                 stage_valid,
    input  branch_pkg::cmp_res_t cmp,
    input  branch_pkg::tgt_res_t tgt,
    output logic                 push,
    output logic                 pop,
    output branch_pkg::xlen_t    push_addr,
    input  branch_pkg::xlen_t    top_addr,
    input  logic                 empty,
    output logic                 res_valid,
    output branch_pkg::br_res_t  res
);
    import branch_pkg::*;

    logic  load;
    logic  taken;
    logic  ret_miss;
    logic  dir_miss;
    xlen_t final_target;

    assign load = advance & stage_valid;

    // branches follow the condition, jumps always go
    assign taken = cmp.is_branch ? cmp.cond_true : tgt.is_jump;

    // fall through to pc+4 when not taken
    assign final_target = taken ? tgt.target : tgt.link;

    assign dir_miss = (taken != tgt.pred_taken);

    // return predicted from the stack top
    assign ret_miss = tgt.is_return && (empty || (top_addr != tgt.target));

    // calls and returns act in program order
    assign push      = load & tgt.is_call;
    assign pop       = load & tgt.is_return;
    assign push_addr = tgt.link;

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (advance) begin
            res_valid <= stage_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            res.pc         <= tgt.pc;
            res.taken      <= taken;
            res.target     <= final_target;
            res.link       <= tgt.link;
            // x0 as rd means nothing to write back
            res.link_valid <= tgt.is_jump & ~tgt.rd_zero;
            res.is_call    <= tgt.is_call;
            res.is_return  <= tgt.is_return;
            res.mispredict <= dir_miss | ret_miss;
        end
    end

endmodule

`default_nettype wire

//--- branch_subsystem.f
branch_pkg.sv
branch_decode.sv
branch_compare.sv
branch_target.sv
return_stack.sv
branch_resolve.sv
branch_subsystem.sv
branch_subsystem_tb.sv

//--- branch_subsystem.sv
// ########################################
// three stages, one shared stall signal
// ras_depth a power of two, at least 2
// ########################################
`timescale 1ns/1ps
`default_nettype none

module branch_subsystem #(
    parameter int ras_depth = 4
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                req_valid,
    output logic                req_ready,
    input  branch_pkg::br_req_t req,
    output logic                res_valid,
    input  logic                res_ready,
    output branch_pkg::br_res_t res
);
    import branch_pkg::*;

    logic     advance;
    logic     op_valid;
    br_op_t   op;
    cmp_res_t cmp;
    logic     tgt_valid;
    tgt_res_t tgt;
    logic     push;
    logic     pop;
    xlen_t    push_addr;
    xlen_t    top_addr;
    logic     empty;

    // whole pipe moves when the output slot frees up
    assign advance   = ~res_valid | res_ready;
    assign req_ready = advance;

    branch_decode u_decode (
        .clk, .rst, .advance, .req_valid, .req, .op_valid, .op
    );

    // compare and target run side by side on the same op
    branch_compare u_compare (
        .clk, .rst, .advance, .op_valid, .op, .cmp
    );

    branch_target u_target (
        .clk, .rst, .advance, .op_valid, .op, .tgt_valid, .tgt
    );

    branch_resolve u_resolve (
        .clk, .rst, .advance,
        .stage_valid (tgt_valid),
        .cmp, .tgt, .push, .pop, .push_addr, .top_addr, .empty,
        .res_valid, .res
    );

    return_stack #(
        .ras_depth (ras_depth)
    ) u_ras (
        .clk, .rst, .push, .pop, .push_addr, .top_addr, .empty
    );

endmodule

`default_nettype wire

//--- branch_subsystem_tb.sv
// ########################################
// directed tests on a ras_depth 4 DUT
// model keeps its own copy of the stack
// ########################################
`timescale 1ns/1ps
`default_nettype none

module branch_subsystem_tb;
    import branch_pkg::*;

    localparam int depth    = 4;
    localparam int max_idle = 200;

    logic    clk;
    logic    rst;
    logic    req_valid;
    logic    req_ready;
    br_req_t req;
    logic    res_valid;
    logic    res_ready;
    br_res_t res;

    logic [31:0] lfsr;
    int          cycle = 0;
    int          errors = 0;
    br_req_t     req_q [$];
    br_res_t     exp_q [$];
    // reference copy of the return stack
    logic [31:0] m_stack [depth];
    int          m_ptr;
    int          m_count;
    logic [2:0]  f3_list [6];

    branch_subsystem #(.ras_depth(depth)) dut (
        .clk, .rst, .req_valid, .req_ready, .req, .res_valid, .res_ready, .res
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // counts rising edges, used for the latency check
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        int          k;
        v = '0;
        for (k = 0; k < n; k++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    // 0 -> x0, 1 -> x1, 2 -> x5, 3 -> x6
    function automatic logic [4:0] pick_reg(input logic [31:0] sel);
        case (sel[1:0])
            2'd0:    return 5'd0;
            2'd1:    return 5'd1;
            2'd2:    return 5'd5;
            default: return 5'd6;
        endcase
    endfunction

    function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [31:0] off,
                                               input logic [4:0] rs1i, input logic [4:0] rs2i);
        return {off[12], off[10:5], rs2i, rs1i, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1i,
                                             input logic [31:0] imm);
        return {imm[11:0], rs1i, 3'b000, rd, 7'b1100111};
    endfunction

    // expected result straight from the ISA rules, updates the model stack
    function automatic br_res_t model_result(input br_req_t r);
        logic [31:0] w;
        logic [31:0] off;
        logic [31:0] tgt;
        logic [31:0] link;
        logic [4:0]  rd;
        logic [4:0]  rs1i;
        logic        is_br;
        logic        is_jalr;
        logic        cond;
        logic        taken;
        logic        call;
        logic        ret;
        br_res_t     e;
        w       = r.instr;
        rd      = w[11:7];
        rs1i    = w[19:15];
        is_br   = (w[6:0] == 7'b1100011);
        is_jalr = (w[6:0] == 7'b1100111);
        link    = r.pc + 32'd4;
        case (w[14:12])
            3'd0:    cond = (r.rs1 == r.rs2);
            3'd1:    cond = (r.rs1 != r.rs2);
            3'd4:    cond = ($signed(r.rs1) < $signed(r.rs2));
            3'd5:    cond = ($signed(r.rs1) >= $signed(r.rs2));
            3'd6:    cond = (r.rs1 < r.rs2);
            3'd7:    cond = (r.rs1 >= r.rs2);
            default: cond = 1'b0;
        endcase
        if (is_br) begin
            off = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            tgt = r.pc + off;
        end else if (is_jalr) begin
            off = {{20{w[31]}}, w[31:20]};
            tgt = (r.rs1 + off) & ~32'd1;
        end else begin
            off = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            tgt = r.pc + off;
        end
        taken = is_br ? cond : 1'b1;
        call  = !is_br && (rd == 5'd1 || rd == 5'd5);
        ret   = is_jalr && (rs1i == 5'd1 || rs1i == 5'd5)
                && (!call || rd != rs1i);
        e.pc         = r.pc;
        e.taken      = taken;
        e.target     = taken ? tgt : link;
        e.link       = link;
        e.link_valid = !is_br && (rd != 5'd0);
        e.is_call    = call;
        e.is_return  = ret;
        e.mispredict = (taken != r.pred_taken)
                       || (ret && (m_count == 0 || m_stack[m_ptr] != tgt));
        // pop before push, oldest entry lost on overflow
        if (ret && m_count != 0) begin
            m_ptr   = (m_ptr + depth - 1) % depth;
            m_count = m_count - 1;
        end
        if (call) begin
            m_ptr          = (m_ptr + 1) % depth;
            m_stack[m_ptr] = link;
            if (m_count < depth) begin
                m_count = m_count + 1;
            end
        end
        return e;
    endfunction

    task automatic check(input logic [127:0] got, input logic [127:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic check_result(input br_res_t got, input br_res_t exp, input int idx);
        string tag;
        tag = $sformatf("result %0d pc %h", idx, exp.pc);
        check(got.pc, exp.pc, {tag, " pc"});
        check(got.taken, exp.taken, {tag, " taken"});
        check(got.target, exp.target, {tag, " target"});
        check(got.link, exp.link, {tag, " link"});
        check(got.link_valid, exp.link_valid, {tag, " link_valid"});
        check(got.is_call, exp.is_call, {tag, " is_call"});
        check(got.is_return, exp.is_return, {tag, " is_return"});
        check(got.mispredict, exp.mispredict, {tag, " mispredict"});
    endtask

    task automatic add_req(input logic [31:0] w, input logic [31:0] pc, input logic [31:0] a,
                           input logic [31:0] b, input logic pred);
        br_req_t r;
        r.instr      = w;
        r.pc         = pc;
        r.rs1        = a;
        r.rs2        = b;
        r.pred_taken = pred;
        req_q.push_back(r);
        exp_q.push_back(model_result(r));
    endtask

    // streams the queued requests, stall drops res_ready at random
    task automatic run_batch(input logic stall);
        int      n;
        int      sent;
        int      got;
        int      idle;
        logic    holding;
        br_res_t held;
        int      accept_q [$];
        n       = req_q.size();
        sent    = 0;
        got     = 0;
        idle    = 0;
        holding = 1'b0;
        held    = '0;
        while (got < n) begin
            @(negedge clk);
            res_ready = stall ? next_bit() : 1'b1;
            req_valid = (sent < n);
            if (sent < n) begin
                req = req_q[sent];
            end
            #5;
            if (holding) begin
                check(res_valid, 1'b1, "res_valid dropped while stalled");
                check(res, held, "payload changed while stalled");
            end
            if (res_valid && res_ready) begin
                check_result(res, exp_q[got], got);
                // accepted at edge N, taken by the consumer at edge N+3
                if (!stall) begin
                    check(cycle + 1 - accept_q[got], 3, "result latency");
                end
                got++;
                holding = 1'b0;
                idle    = 0;
            end else if (res_valid) begin
                held    = res;
                holding = 1'b1;
            end
            if (req_valid && req_ready) begin
                accept_q.push_back(cycle + 1);
                sent++;
                idle = 0;
            end
            idle++;
            if (idle > max_idle) begin
                $display("timeout: no handshake within %0d cycles", max_idle);
                $display("Simulation failed");
                $fatal(1, "pipeline stopped moving");
            end
        end
        @(negedge clk);
        res_ready = 1'b1;
        #5;
        check(res_valid, 1'b0, "extra result after the batch");
        req_q.delete();
        exp_q.delete();
    endtask

    // every condition, edge and random operands, both predictions
    task automatic test_branches();
        logic [31:0] a [5];
        logic [31:0] b [5];
        logic [31:0] w;
        logic [31:0] pc;
        int          i;
        int          j;
        for (i = 0; i < 6; i++) begin
            a[0] = next_bits(32);
            b[0] = a[0];
            a[1] = 32'h8000_0000;
            b[1] = 32'h0000_0001;
            a[2] = 32'h7fff_ffff;
            b[2] = 32'hffff_ffff;
            a[3] = next_bits(32);
            b[3] = next_bits(32);
            // only the sign bit differs
            a[4] = next_bits(32);
            b[4] = {~a[4][31], a[4][30:0]};
            for (j = 0; j < 5; j++) begin
                w  = enc_branch(f3_list[i], next_bits(12) << 1, 5'd3, 5'd4);
                pc = {next_bits(30), 2'b00};
                add_req(w, pc, a[j], b[j], 1'b0);
                add_req(w, pc + 32'd8, a[j], b[j], 1'b1);
            end
        end
        run_batch(1'b0);
    endtask

    // plain jumps, no link registers involved
    task automatic test_jumps();
        logic [31:0] w;
        logic [4:0]  rd;
        int          i;
        for (i = 0; i < 8; i++) begin
            rd = (i < 4) ? 5'd0 : 5'(8 + i);
            if (i % 2 == 0) begin
                w = enc_jal(rd, next_bits(20) << 1);
            end else begin
                w = enc_jalr(rd, 5'(10 + i), next_bits(12));
            end
            add_req(w, {next_bits(30), 2'b00}, next_bits(32), 32'd0, i[1]);
        end
        run_batch(1'b0);
    endtask

    task automatic test_call_return();
        logic [31:0] base;
        logic [31:0] pc;
        logic [31:0] links [$];
        int          i;
        base = 32'h0000_4000;
        // stack is still empty here
        add_req(enc_jalr(5'd0, 5'd1, 0), base, 32'h100, 32'd0, 1'b1);
        // six nested calls overflow a four-entry stack
        for (i = 0; i < 6; i++) begin
            pc = base + 32'(64 * i);
            add_req(enc_jal((i % 2) ? 5'd5 : 5'd1, 32'h40), pc, 32'd0, 32'd0, 1'b1);
            links.push_back(pc + 32'd4);
        end
        for (i = 0; i < 6; i++) begin
            add_req(enc_jalr(5'd0, (i % 2) ? 5'd1 : 5'd5, 0), base + 32'h800 + 32'(8 * i),
                    links.pop_back(), 32'd0, 1'b1);
        end
        // return to the wrong address
        add_req(enc_jal(5'd1, 32'h100), base + 32'h1000, 32'd0, 32'd0, 1'b1);
        add_req(enc_jalr(5'd0, 5'd1, 0), base + 32'h1100, base + 32'h1008, 32'd0, 1'b1);
        // coroutine swap, pop and push in one go
        add_req(enc_jal(5'd1, 32'h20), base + 32'h2000, 32'd0, 32'd0, 1'b1);
        add_req(enc_jalr(5'd1, 5'd5, 0), base + 32'h2020, base + 32'h2004, 32'd0, 1'b1);
        add_req(enc_jalr(5'd0, 5'd1, 0), base + 32'h3000, base + 32'h2024, 32'd0, 1'b1);
        run_batch(1'b1);
    endtask

    // random mix under random back-pressure
    task automatic test_backpressure();
        logic [31:0] w;
        int          i;
        for (i = 0; i < 40; i++) begin
            case (next_bits(2))
                32'd0, 32'd1: w = enc_branch(f3_list[next_bits(3) % 6], next_bits(12) << 1,
                                             5'd7, 5'd8);
                32'd2:        w = enc_jal(pick_reg(next_bits(2)), next_bits(20) << 1);
                default:      w = enc_jalr(pick_reg(next_bits(2)), pick_reg(next_bits(2)),
                                           next_bits(12));
            endcase
            add_req(w, {next_bits(30), 2'b00}, next_bits(32), next_bits(32), next_bit());
        end
        run_batch(1'b1);
    endtask

    initial begin
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        res_ready = 1'b1;
        lfsr      = 32'h42e2df90;
        m_ptr     = 0;
        m_count   = 0;
        f3_list   = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #5;
        check(req_ready, 1'b1, "req_ready after reset");
        check(res_valid, 1'b0, "res_valid after reset");
        test_branches();
        test_jumps();
        test_call_return();
        test_backpressure();
        if (errors == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            $display("Simulation failed");
            $fatal(1, "mismatches were counted");
        end
    end

endmodule

`default_nettype wire

//--- branch_target.sv
// ########################################
// misaligned targets raise no exception
// jalr target has bit 0 forced low
// ########################################
`timescale 1ns/1ps
`default_nettype none

module branch_target (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 advance,
    input  logic                 op_valid,
    input  branch_pkg::br_op_t   op,
    output logic                 tgt_valid,
    output branch_pkg::tgt_res_t tgt
);
    import branch_pkg::*;

    xlen_t base;
    xlen_t sum;

    // jalr is register relative, everything else pc relative
    assign base = op.is_jalr ? op.rs1 : op.pc;
    assign sum  = base + op.offset;

    always_ff @(posedge clk) begin
        if (rst) begin
            tgt_valid <= 1'b0;
        end else if (advance) begin
            tgt_valid <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            tgt.target     <= {sum[31:1], sum[0] & ~op.is_jalr};
            tgt.link       <= op.pc + 32'd4;
            tgt.is_jump    <= op.is_jal | op.is_jalr;
            // hint flags travel with the target for the stack
            tgt.rd_zero    <= op.rd_zero;
            tgt.is_call    <= op.is_call;
            tgt.is_return  <= op.is_return;
            tgt.pc         <= op.pc;
            tgt.pred_taken <= op.pred_taken;
        end
    end

endmodule

`default_nettype wire

//--- return_stack.sv
// ########################################
// ras_depth must be a power of two, >= 2
// full push drops the oldest entry
// ########################################
`timescale 1ns/1ps
`default_nettype none

module return_stack #(
    parameter int ras_depth = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              push,
    input  logic              pop,
    input  branch_pkg::xlen_t push_addr,
    output branch_pkg::xlen_t top_addr,
    output logic              empty
);
    import branch_pkg::*;

    localparam int ptr_w = $clog2(ras_depth);
    localparam int cnt_w = ptr_w + 1;
    localparam logic [cnt_w-1:0] full_count = cnt_w'(ras_depth);

    xlen_t            mem [ras_depth];
    logic [ptr_w-1:0] top_ptr;
    logic [ptr_w-1:0] ptr_next;
    logic [cnt_w-1:0] count;
    logic [cnt_w-1:0] cnt_next;

    assign empty    = (count == '0);
    assign top_addr = mem[top_ptr];

    // pop first, then push, so a call-return pair replaces the top
    always_comb begin
        ptr_next = top_ptr;
        cnt_next = count;
        if (pop && !empty) begin
            ptr_next = ptr_next - 1'b1;
            cnt_next = cnt_next - 1'b1;
        end
        if (push) begin
            ptr_next = ptr_next + 1'b1;
            // count saturates, the pointer wraps over the oldest
            if (cnt_next != full_count) begin
                cnt_next = cnt_next + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            top_ptr <= '0;
            count   <= '0;
        end else begin
            top_ptr <= ptr_next;
            count   <= cnt_next;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[ptr_next] <= push_addr;
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= full_count)
        else $error("return stack count above depth");

endmodule

`default_nettype wire
